// ==== logic/id_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction decoder
// Opcode and funct decoding into operators, selectors, immediates,
// register addresses, instruction class and illegal flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module id_decoder import id_pkg::*; #(
  parameter bit RV32M = 1'b1,
  parameter bit RV32E = 1'b0
) (
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  output alu_op_e   alu_operator_o,
  output md_op_e    md_operator_o,
  output op_a_sel_e op_a_sel_o,
  output op_b_sel_e op_b_sel_o,
  output imm_sel_e  imm_sel_o,
  output word_t     imm_i_o,
  output word_t     imm_s_o,
  output word_t     imm_u_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o,
  output logic      rf_we_dec_o,
  output logic      is_multdiv_o,
  output logic      is_lsu_o,
  output logic      lsu_we_o,
  output lsu_type_t lsu_type_o,
  output logic      illegal_insn_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal_enc;
  logic       illegal_reg;
  logic       illegal_any;
  logic       rs1_used;
  logic       rs2_used;
  logic       rf_we_raw;
  logic       is_multdiv_raw;
  logic       is_lsu_raw;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register fields sit at fixed positions
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];
  assign rf_waddr_o   = instr_i[11:7];

  // Sign extended immediates
  assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_o = {instr_i[31:12], 12'b0};

  // Access size from funct3, sign bit is funct3[2]
  always_comb begin
    case (funct3[1:0])
      2'b00:   lsu_type_o = LSU_BYTE;
      2'b01:   lsu_type_o = LSU_HALF;
      default: lsu_type_o = LSU_WORD;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Main decode
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_operator_o = ALU_ADD;
    md_operator_o  = MD_OP_MULL;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_REG_B;
    imm_sel_o      = IMM_I;
    rs1_used       = 1'b0;
    rs2_used       = 1'b0;
    rf_we_raw      = 1'b0;
    is_multdiv_raw = 1'b0;
    is_lsu_raw     = 1'b0;
    lsu_we_o       = 1'b0;
    illegal_enc    = 1'b0;

    unique case (opcode_e'(instr_i[6:0]))
      OPCODE_LUI: begin
        // Zero plus upper immediate
        op_a_sel_o = OP_A_ZERO;
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_U;
        rf_we_raw  = 1'b1;
      end
      OPCODE_AUIPC: begin
        op_a_sel_o = OP_A_CURRPC;
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_U;
        rf_we_raw  = 1'b1;
      end
      OPCODE_OP_IMM: begin
        op_b_sel_o = OP_B_IMM;
        rs1_used   = 1'b1;
        rf_we_raw  = 1'b1;
        unique case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_enc    = (funct7 != 7'h00);
          end
          3'b101: begin
            // Shift type in funct7
            alu_operator_o = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            illegal_enc    = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPCODE_OP: begin
        rs1_used  = 1'b1;
        rs2_used  = 1'b1;
        rf_we_raw = 1'b1;
        if (funct7 == 7'h01) begin
          // M extension, signedness variants share an operator
          is_multdiv_raw = 1'b1;
          illegal_enc    = !RV32M;
          unique case (funct3[2:1])
            2'b00: md_operator_o = funct3[0] ? MD_OP_MULH : MD_OP_MULL;
            2'b01: md_operator_o = MD_OP_MULH;
            2'b10: md_operator_o = MD_OP_DIV;
            2'b11: md_operator_o = MD_OP_REM;
          endcase
        end else begin
          unique case ({funct7, funct3})
            {7'h00, 3'b000}: alu_operator_o = ALU_ADD;
            {7'h20, 3'b000}: alu_operator_o = ALU_SUB;
            {7'h00, 3'b001}: alu_operator_o = ALU_SLL;
            {7'h00, 3'b010}: alu_operator_o = ALU_SLT;
            {7'h00, 3'b011}: alu_operator_o = ALU_SLTU;
            {7'h00, 3'b100}: alu_operator_o = ALU_XOR;
            {7'h00, 3'b101}: alu_operator_o = ALU_SRL;
            {7'h20, 3'b101}: alu_operator_o = ALU_SRA;
            {7'h00, 3'b110}: alu_operator_o = ALU_OR;
            {7'h00, 3'b111}: alu_operator_o = ALU_AND;
            default:         illegal_enc    = 1'b1;
          endcase
        end
      end
      OPCODE_LOAD: begin
        // Address is rs1 plus I immediate
        op_b_sel_o  = OP_B_IMM;
        rs1_used    = 1'b1;
        rf_we_raw   = 1'b1;
        is_lsu_raw  = 1'b1;
        illegal_enc = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPCODE_STORE: begin
        op_b_sel_o  = OP_B_IMM;
        imm_sel_o   = IMM_S;
        rs1_used    = 1'b1;
        rs2_used    = 1'b1;
        is_lsu_raw  = 1'b1;
        lsu_we_o    = 1'b1;
        illegal_enc = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal_enc = 1'b1;
    endcase
  end

  // RV32E has only x0 to x15
  assign illegal_reg = RV32E & ((rs1_used & instr_i[19]) | (rs2_used & instr_i[24]) |
                                (rf_we_raw & instr_i[11]));
  assign illegal_any = illegal_enc | illegal_reg;

  // Illegal instructions start nothing and write nothing
  assign illegal_insn_o = instr_valid_i & illegal_any;
  assign rf_we_dec_o    = rf_we_raw & ~illegal_any;
  assign is_multdiv_o   = is_multdiv_raw & ~illegal_any;
  assign is_lsu_o       = is_lsu_raw & ~illegal_any;

  // Stall FSM relies on one multicycle class at a time
  always_comb begin
    assert (!(is_multdiv_o && is_lsu_o))
      else $error("multdiv and lsu decoded together");
  end

endmodule

// ==== logic/id_operand_mux.sv ====
////////////////////////////////////////////////////////////////////////////
// ALU operand selection
// Immediate mux, operand A and operand B muxes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module id_operand_mux import id_pkg::*; (
  input  op_a_sel_e op_a_sel_i,
  input  op_b_sel_e op_b_sel_i,
  input  imm_sel_e  imm_sel_i,
  input  word_t     imm_i_i,
  input  word_t     imm_s_i,
  input  word_t     imm_u_i,
  input  word_t     pc_i,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output word_t     alu_operand_a_o,
  output word_t     alu_operand_b_o
);

  word_t imm;

  // Immediate for operand B
  always_comb begin
    unique case (imm_sel_i)
      IMM_I:   imm = imm_i_i;
      IMM_S:   imm = imm_s_i;
      IMM_U:   imm = imm_u_i;
      default: imm = '0;
    endcase
  end

  // Operand A from register, PC or zero
  always_comb begin
    unique case (op_a_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_i;
      OP_A_ZERO:   alu_operand_a_o = '0;
      default:     alu_operand_a_o = '0;
    endcase
  end

  // Operand B from register or immediate
  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm : rf_rdata_b_i;

  // Decoder never picks the spare immediate encoding for an immediate operand
  always_comb begin
    assert (op_b_sel_i != OP_B_IMM || imm_sel_i inside {IMM_I, IMM_S, IMM_U})
      else $error("unused immediate selected");
  end

endmodule

// ==== logic/id_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the decode stage
// Data and register index types, major opcodes, ALU and multiplier
// operators, operand and immediate selectors, LSU access sizes
////////////////////////////////////////////////////////////////////////////

package id_pkg;

  // Data word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Supported major opcodes
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37
  } opcode_e;

  // ALU operators
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // Multiplier and divider operators
  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;

  // Operand selectors
  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // Immediate selector, encoding 3 unused
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_sel_e;

  // LSU access size
  typedef logic [1:0] lsu_type_t;

  localparam lsu_type_t LSU_WORD = 2'b00;
  localparam lsu_type_t LSU_HALF = 2'b01;
  localparam lsu_type_t LSU_BYTE = 2'b10;

endpackage

// ==== logic/id_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction decode stage top
// Decoder, operand muxes and stall FSM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module id_stage import id_pkg::*; #(
  parameter bit RV32M = 1'b1,
  parameter bit RV32E = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  input  logic      ex_valid_i,
  input  logic      lsu_resp_valid_i,
  output logic      id_in_ready_o,
  output logic      instr_done_o,
  output logic      illegal_insn_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o,
  output logic      rf_we_o,
  output alu_op_e   alu_operator_o,
  output word_t     alu_operand_a_o,
  output word_t     alu_operand_b_o,
  output logic      multdiv_en_o,
  output md_op_e    md_operator_o,
  output logic      lsu_req_o,
  output logic      lsu_we_o,
  output lsu_type_t lsu_type_o,
  output word_t     lsu_wdata_o
);

  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  imm_sel_e  imm_sel;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_u;
  logic      rf_we_dec;
  logic      is_multdiv;
  logic      is_lsu;

  // Decode
  id_decoder #(
    .RV32M(RV32M),
    .RV32E(RV32E)
  ) u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .alu_operator_o(alu_operator_o),
    .md_operator_o (md_operator_o),
    .op_a_sel_o    (op_a_sel),
    .op_b_sel_o    (op_b_sel),
    .imm_sel_o     (imm_sel),
    .imm_i_o       (imm_i),
    .imm_s_o       (imm_s),
    .imm_u_o       (imm_u),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_we_dec_o   (rf_we_dec),
    .is_multdiv_o  (is_multdiv),
    .is_lsu_o      (is_lsu),
    .lsu_we_o      (lsu_we_o),
    .lsu_type_o    (lsu_type_o),
    .illegal_insn_o(illegal_insn_o)
  );

  // Operands
  id_operand_mux u_operand_mux (
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_sel_i      (imm_sel),
    .imm_i_i        (imm_i),
    .imm_s_i        (imm_s),
    .imm_u_i        (imm_u),
    .pc_i           (pc_i),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  // Stall control
  id_stall_fsm u_stall_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid_i),
    .illegal_insn_i  (illegal_insn_o),
    .is_multdiv_i    (is_multdiv),
    .is_lsu_i        (is_lsu),
    .rf_we_dec_i     (rf_we_dec),
    .ex_valid_i      (ex_valid_i),
    .lsu_resp_valid_i(lsu_resp_valid_i),
    .id_in_ready_o   (id_in_ready_o),
    .instr_done_o    (instr_done_o),
    .rf_we_o         (rf_we_o),
    .lsu_req_o       (lsu_req_o),
    .multdiv_en_o    (multdiv_en_o)
  );

  // Store data straight from register file, no forwarding
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

// ==== logic/id_stall_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stall FSM
// First-cycle and multi-cycle tracking, stall and done generation,
// LSU request, multdiv enable and write enable gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module id_stall_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic illegal_insn_i,
  input  logic is_multdiv_i,
  input  logic is_lsu_i,
  input  logic rf_we_dec_i,
  input  logic ex_valid_i,
  input  logic lsu_resp_valid_i,
  output logic id_in_ready_o,
  output logic instr_done_o,
  output logic rf_we_o,
  output logic lsu_req_o,
  output logic multdiv_en_o
);

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  id_fsm_e state_q;
  id_fsm_e state_d;
  logic    first_cycle;
  logic    lsu_active;
  logic    md_active;
  logic    stall_mem;
  logic    stall_multdiv;
  logic    stall;
  logic    done;

  // Only a valid, legal instruction counts
  assign lsu_active = instr_valid_i & is_lsu_i & ~illegal_insn_i;
  assign md_active  = instr_valid_i & is_multdiv_i & ~illegal_insn_i;

  assign first_cycle = instr_valid_i & (state_q == FIRST_CYCLE);

  // Memory access stalls its first cycle and waits for the response
  assign stall_mem = lsu_active & (~lsu_resp_valid_i | first_cycle);

  // Multdiv may finish in its first cycle
  assign stall_multdiv = md_active & ~ex_valid_i;

  assign stall = stall_mem | stall_multdiv;
  assign done  = instr_valid_i & ~stall;

  //////////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (instr_valid_i) begin
      unique case (state_q)
        FIRST_CYCLE: if (stall) state_d = MULTI_CYCLE;
        MULTI_CYCLE: if (done) state_d = FIRST_CYCLE;
        default:     state_d = FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FIRST_CYCLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Handshake and completion
  assign id_in_ready_o = done;
  assign instr_done_o  = done;

  // Write back only in the completing cycle
  assign rf_we_o      = done & rf_we_dec_i & ~illegal_insn_i;
  assign lsu_req_o    = lsu_active & first_cycle;
  assign multdiv_en_o = md_active;

  // Multi-cycle state only follows a stalled cycle with the buffer held
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == MULTI_CYCLE) |-> $past(stall));

  // A handshake frees the stage for the first cycle of the next instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_in_ready_o |=> (state_q == FIRST_CYCLE));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_id_stage -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

// ==== tb.f ====
+incdir+verification
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operand_mux.sv
logic/id_stall_fsm.sv
logic/id_stage.sv
verification/tb_id_stage.sv

// ==== verification/tb_id_ref.svh ====
////////////////////////////////////////////////////////////////////////////
// Testbench reference helpers
// ISA opcodes, instruction encoders, immediate extension, Galois LFSR
////////////////////////////////////////////////////////////////////////////

`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

// Major opcodes as listed in the RV32 base ISA
localparam logic [6:0] OPC_LOAD   = 7'h03;
localparam logic [6:0] OPC_OP_IMM = 7'h13;
localparam logic [6:0] OPC_AUIPC  = 7'h17;
localparam logic [6:0] OPC_STORE  = 7'h23;
localparam logic [6:0] OPC_OP     = 7'h33;
localparam logic [6:0] OPC_LUI    = 7'h37;

// x^32 + x^22 + x^2 + x + 1, right shifting form
localparam logic [31:0] LFSR_SEED = 32'h4dc6;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state;

// R-type, always the OP opcode
function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

// Store immediate split around the funct3 field
function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] sext12(logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// One LFSR step per bit taken, output bit is the shifted out LSB
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] val;
  int          i;
  val = '0;
  for (i = 0; i < n; i++) begin
    val        = {val[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
  end
  return val;
endfunction

`endif

// ==== verification/tb_id_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stage testbench
// Clock, reset, DUT, directed tests per instruction class, timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_id_stage import id_pkg::*; ();

  // Tests take under 80 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic      clk_i;
  logic      rst_ni;
  logic      instr_valid_i;
  word_t     instr_i;
  word_t     pc_i;
  word_t     rf_rdata_a_i;
  word_t     rf_rdata_b_i;
  logic      ex_valid_i;
  logic      lsu_resp_valid_i;
  logic      id_in_ready_o;
  logic      instr_done_o;
  logic      illegal_insn_o;
  reg_addr_t rf_raddr_a_o;
  reg_addr_t rf_raddr_b_o;
  reg_addr_t rf_waddr_o;
  logic      rf_we_o;
  alu_op_e   alu_operator_o;
  word_t     alu_operand_a_o;
  word_t     alu_operand_b_o;
  logic      multdiv_en_o;
  md_op_e    md_operator_o;
  logic      lsu_req_o;
  logic      lsu_we_o;
  lsu_type_t lsu_type_o;
  word_t     lsu_wdata_o;

  int err_cnt   = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;
  int cycle_cnt = 0;

  `include "tb_id_ref.svh"

  id_stage #(
    .RV32M(1'b1),
    .RV32E(1'b0)
  ) uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .ex_valid_i      (ex_valid_i),
    .lsu_resp_valid_i(lsu_resp_valid_i),
    .id_in_ready_o   (id_in_ready_o),
    .instr_done_o    (instr_done_o),
    .illegal_insn_o  (illegal_insn_o),
    .rf_raddr_a_o    (rf_raddr_a_o),
    .rf_raddr_b_o    (rf_raddr_b_o),
    .rf_waddr_o      (rf_waddr_o),
    .rf_we_o         (rf_we_o),
    .alu_operator_o  (alu_operator_o),
    .alu_operand_a_o (alu_operand_a_o),
    .alu_operand_b_o (alu_operand_b_o),
    .multdiv_en_o    (multdiv_en_o),
    .md_operator_o   (md_operator_o),
    .lsu_req_o       (lsu_req_o),
    .lsu_we_o        (lsu_we_o),
    .lsu_type_o      (lsu_type_o),
    .lsu_wdata_o     (lsu_wdata_o)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Hang guard
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the edge
  task automatic next_drive_slot();
    @(posedge clk_i);
    #1;
  endtask

  // Outputs settle by 1 ns before the next edge
  task automatic settle();
    #2;
  endtask

  task automatic apply_instr(input word_t instr, input word_t pc, input word_t a, input word_t b);
    instr_valid_i = 1'b1;
    instr_i       = instr;
    pc_i          = pc;
    rf_rdata_a_i  = a;
    rf_rdata_b_i  = b;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // Zero latency completion of a single cycle instruction
  task automatic expect_single_done(input logic exp_we);
    expect_eq("id_in_ready_o", 32'(1'b1), 32'(id_in_ready_o));
    expect_eq("instr_done_o", 32'(1'b1), 32'(instr_done_o));
    expect_eq("rf_we_o", 32'(exp_we), 32'(rf_we_o));
    expect_eq("illegal_insn_o", 32'(1'b0), 32'(illegal_insn_o));
    expect_eq("lsu_req_o", 32'(1'b0), 32'(lsu_req_o));
    expect_eq("multdiv_en_o", 32'(1'b0), 32'(multdiv_en_o));
  endtask

  // Valid dropped with the last instruction left on the bus
  task automatic idle_cycle();
    next_drive_slot();
    instr_valid_i    = 1'b0;
    ex_valid_i       = 1'b0;
    lsu_resp_valid_i = 1'b0;
    settle();
    expect_eq("id_in_ready_o", 32'(1'b0), 32'(id_in_ready_o));
    expect_eq("instr_done_o", 32'(1'b0), 32'(instr_done_o));
    expect_eq("rf_we_o", 32'(1'b0), 32'(rf_we_o));
    expect_eq("lsu_req_o", 32'(1'b0), 32'(lsu_req_o));
    expect_eq("multdiv_en_o", 32'(1'b0), 32'(multdiv_en_o));
    expect_eq("illegal_insn_o", 32'(1'b0), 32'(illegal_insn_o));
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Single cycle classes
  //////////////////////////////////////////////////////////////////////////

  task automatic op_imm_case(input logic [2:0] f3, input logic [11:0] imm,
                             input logic [4:0] rs1, input logic [4:0] rd, input alu_op_e exp_op);
    word_t a;
    a = rand_bits(32);
    next_drive_slot();
    apply_instr(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), 32'h0000_0100, a, rand_bits(32));
    settle();
    expect_eq("alu_operand_a_o", a, alu_operand_a_o);
    expect_eq("alu_operand_b_o", sext12(imm), alu_operand_b_o);
    expect_eq("alu_operator_o", 32'(exp_op), 32'(alu_operator_o));
    expect_eq("rf_raddr_a_o", 32'(rs1), 32'(rf_raddr_a_o));
    expect_eq("rf_waddr_o", 32'(rd), 32'(rf_waddr_o));
    expect_single_done(1'b1);
    idle_cycle();
  endtask

  task automatic op_imm_group();
    int errs;
    errs = err_cnt;
    op_imm_case(3'b000, 12'hffb, 5'd3, 5'd5, ALU_ADD);
    op_imm_case(3'b100, 12'hfff, 5'd9, 5'd7, ALU_XOR);
    // SRAI carries funct7 0x20 in the upper immediate bits
    op_imm_case(3'b101, 12'h403, 5'd11, 5'd10, ALU_SRA);
    close_test("OP-IMM", errs);
  endtask

  task automatic upper_case(input logic [6:0] opc, input logic [19:0] imm, input logic [4:0] rd,
                            input word_t pc, input word_t exp_a);
    next_drive_slot();
    apply_instr(enc_u(imm, rd, opc), pc, rand_bits(32), rand_bits(32));
    settle();
    expect_eq("alu_operand_a_o", exp_a, alu_operand_a_o);
    expect_eq("alu_operand_b_o", {imm, 12'h000}, alu_operand_b_o);
    expect_eq("rf_waddr_o", 32'(rd), 32'(rf_waddr_o));
    expect_single_done(1'b1);
    idle_cycle();
  endtask

  task automatic lui_auipc();
    int errs;
    errs = err_cnt;
    upper_case(OPC_LUI, 20'hdead5, 5'd4, 32'h0040_0120, 32'h0);
    upper_case(OPC_AUIPC, 20'h80001, 5'd6, 32'h0040_0124, 32'h0040_0124);
    close_test("LUI/AUIPC", errs);
  endtask

  task automatic reg_case(input logic [6:0] f7, input logic [2:0] f3, input alu_op_e exp_op,
                          output logic [3:0] op_seen);
    word_t a;
    word_t b;
    a = rand_bits(32);
    b = rand_bits(32);
    next_drive_slot();
    apply_instr(enc_r(f7, 5'd18, 5'd17, f3, 5'd20), 32'h0000_0180, a, b);
    settle();
    expect_eq("rf_raddr_a_o", 32'(5'd17), 32'(rf_raddr_a_o));
    expect_eq("rf_raddr_b_o", 32'(5'd18), 32'(rf_raddr_b_o));
    expect_eq("alu_operand_a_o", a, alu_operand_a_o);
    expect_eq("alu_operand_b_o", b, alu_operand_b_o);
    expect_eq("alu_operator_o", 32'(exp_op), 32'(alu_operator_o));
    expect_single_done(1'b1);
    op_seen = alu_operator_o;
    idle_cycle();
  endtask

  task automatic reg_reg_ops();
    int         errs;
    logic [3:0] add_op;
    logic [3:0] sub_op;
    logic [3:0] other_op;
    errs = err_cnt;
    reg_case(7'h00, 3'b000, ALU_ADD, add_op);
    reg_case(7'h20, 3'b000, ALU_SUB, sub_op);
    reg_case(7'h00, 3'b011, ALU_SLTU, other_op);
    reg_case(7'h00, 3'b111, ALU_AND, other_op);
    assert (add_op != sub_op) else begin
      $display("ADD and SUB were decoded to the same ALU operator");
      err_cnt++;
    end
    close_test("OP", errs);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Multicycle classes
  //////////////////////////////////////////////////////////////////////////

  // ex_valid_i pulses delay cycles after the first cycle
  task automatic md_case(input logic [2:0] f3, input md_op_e exp_op, input int delay);
    word_t a;
    word_t b;
    int    k;
    bit    seen;
    a    = rand_bits(32);
    b    = rand_bits(32);
    k    = 0;
    seen = 1'b0;
    while (!seen && k <= delay + 2) begin
      next_drive_slot();
      if (k == 0) apply_instr(enc_r(7'h01, 5'd12, 5'd13, f3, 5'd14), 32'h0000_0200, a, b);
      ex_valid_i = (k == delay);
      settle();
      expect_eq("multdiv_en_o", 32'(1'b1), 32'(multdiv_en_o));
      expect_eq("md_operator_o", 32'(exp_op), 32'(md_operator_o));
      expect_eq("alu_operand_a_o", a, alu_operand_a_o);
      expect_eq("alu_operand_b_o", b, alu_operand_b_o);
      expect_eq("id_in_ready_o", 32'(k == delay), 32'(id_in_ready_o));
      expect_eq("instr_done_o", 32'(k == delay), 32'(instr_done_o));
      expect_eq("rf_we_o", 32'(k == delay), 32'(rf_we_o));
      seen = id_in_ready_o;
      k++;
    end
    assert (seen) else begin
      $display("Multiply/divide funct3 %0d never handshaked after ex_valid_i", f3);
      err_cnt++;
    end
    idle_cycle();
  endtask

  task automatic mul_div();
    int errs;
    errs = err_cnt;
    md_case(3'b000, MD_OP_MULL, int'(rand_bits(3) % 6));
    md_case(3'b100, MD_OP_DIV, int'(rand_bits(3) % 6));
    // Result ready in the first cycle
    md_case(3'b000, MD_OP_MULL, 0);
    close_test("MUL/DIV", errs);
  endtask

  task automatic lsu_case(input bit store, input logic [2:0] f3, input logic [11:0] imm,
                          input lsu_type_t exp_type, input int delay);
    word_t a;
    word_t b;
    word_t instr;
    int    k;
    bit    seen;
    a     = rand_bits(32);
    b     = rand_bits(32);
    instr = store ? enc_s(imm, 5'd21, 5'd22, f3) : enc_i(imm, 5'd22, f3, 5'd23, OPC_LOAD);
    k     = 0;
    seen  = 1'b0;
    while (!seen && k <= delay + 2) begin
      next_drive_slot();
      if (k == 0) apply_instr(instr, 32'h0000_0300, a, b);
      lsu_resp_valid_i = (k == delay);
      settle();
      expect_eq("lsu_req_o", 32'(k == 0), 32'(lsu_req_o));
      expect_eq("alu_operand_a_o", a, alu_operand_a_o);
      expect_eq("alu_operand_b_o", sext12(imm), alu_operand_b_o);
      expect_eq("lsu_wdata_o", b, lsu_wdata_o);
      expect_eq("lsu_we_o", 32'(store), 32'(lsu_we_o));
      expect_eq("lsu_type_o", 32'(exp_type), 32'(lsu_type_o));
      expect_eq("id_in_ready_o", 32'(k == delay), 32'(id_in_ready_o));
      expect_eq("rf_we_o", 32'(!store && k == delay), 32'(rf_we_o));
      seen = id_in_ready_o;
      k++;
    end
    assert (seen) else begin
      $display("LSU access funct3 %0d never handshaked after lsu_resp_valid_i", f3);
      err_cnt++;
    end
    idle_cycle();
  endtask

  task automatic load_store();
    int errs;
    errs = err_cnt;
    lsu_case(1'b0, 3'b010, 12'h7f0, LSU_WORD, 1 + int'(rand_bits(2)));
    lsu_case(1'b0, 3'b101, 12'hffc, LSU_HALF, 1 + int'(rand_bits(2)));
    lsu_case(1'b1, 3'b010, 12'h8a4, LSU_WORD, 1 + int'(rand_bits(2)));
    lsu_case(1'b1, 3'b000, 12'h03c, LSU_BYTE, 1 + int'(rand_bits(2)));
    close_test("LOAD/STORE", errs);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Illegal encodings
  //////////////////////////////////////////////////////////////////////////

  task automatic illegal_case(input word_t instr);
    next_drive_slot();
    apply_instr(instr, 32'h0000_0400, rand_bits(32), rand_bits(32));
    settle();
    expect_eq("illegal_insn_o", 32'(1'b1), 32'(illegal_insn_o));
    expect_eq("instr_done_o", 32'(1'b1), 32'(instr_done_o));
    expect_eq("rf_we_o", 32'(1'b0), 32'(rf_we_o));
    expect_eq("lsu_req_o", 32'(1'b0), 32'(lsu_req_o));
    expect_eq("multdiv_en_o", 32'(1'b0), 32'(multdiv_en_o));
    idle_cycle();
  endtask

  task automatic illegal_encodings();
    int errs;
    errs = err_cnt;
    // Unsupported custom-0 opcode
    illegal_case(32'h1234_500b);
    illegal_case(enc_r(7'h10, 5'd1, 5'd2, 3'b000, 5'd3));
    close_test("Illegal", errs);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni           = 1'b0;
    instr_valid_i    = 1'b0;
    instr_i          = '0;
    pc_i             = '0;
    rf_rdata_a_i     = '0;
    rf_rdata_b_i     = '0;
    ex_valid_i       = 1'b0;
    lsu_resp_valid_i = 1'b0;
    lfsr_state       = LFSR_SEED;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    idle_cycle();
    op_imm_group();
    lui_auipc();
    reg_reg_ops();
    mul_div();
    load_store();
    illegal_encodings();
    $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
